// ==== design/corePkg.sv ====
package corePkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int dataW    = 16;
   localparam int regAddrW = 3;
   localparam int numRegs  = 1 << regAddrW;
   localparam int immW     = 6;
   localparam int shamtW   = 4;                 // shift amount taken from opB

   // ------------------------------------------------------------------------
   // opcodes
   // ------------------------------------------------------------------------
   // values 11 to 15 are left free and decode as NOP
   typedef enum logic [3:0] {
      opAdd  = 4'd0,
      opSub  = 4'd1,
      opAnd  = 4'd2,
      opOr   = 4'd3,
      opXor  = 4'd4,
      opShl  = 4'd5,
      opShr  = 4'd6,
      opMovi = 4'd7,
      opAddi = 4'd8,
      opCmp  = 4'd9,
      opMovz = 4'd10
   } opcode_t;

   // instruction word with imm overlaid as {rb, immLo}
   typedef struct packed {
      opcode_t             op;                  // 15:12
      logic [regAddrW-1:0] rd;                  // 11:9
      logic [regAddrW-1:0] ra;                  // 8:6
      logic [regAddrW-1:0] rb;                  // 5:3
      logic [2:0]          immLo;               // 2:0
   } instr_t;

   typedef struct packed {
      opcode_t             op;
      logic                regWrite;
      logic                flagWrite;
      logic                useImm;
      logic                condZero;            // write only when Z is set
      logic [regAddrW-1:0] rd;
      logic [regAddrW-1:0] ra;
      logic [regAddrW-1:0] rb;
      logic [dataW-1:0]    imm;                 // already sign-extended
   } ctrl_t;

   typedef struct packed {
      logic z;
      logic n;
      logic c;
   } flags_t;

   typedef struct packed {
      logic             valid;
      ctrl_t            ctrl;
      logic [dataW-1:0] opA;
      logic [dataW-1:0] opB;
   } exStage_t;

   typedef struct packed {
      logic                valid;
      logic                regWrite;
      logic [regAddrW-1:0] rd;
      logic [dataW-1:0]    data;
   } wb_t;

endpackage

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
   input  corePkg::instr_t instr,
   output corePkg::ctrl_t  ctrl
);
   import corePkg::*;

   logic [immW-1:0] immRaw;

   assign immRaw = {instr.rb, instr.immLo};

   // ------------------------------------------------------------------------
   // field split and per-opcode control bits
   // ------------------------------------------------------------------------
   always_comb begin
      ctrl           = '0;
      ctrl.op        = instr.op;
      ctrl.rd        = instr.rd;
      ctrl.ra        = instr.ra;
      ctrl.rb        = instr.rb;
      ctrl.imm       = {{(dataW-immW){immRaw[immW-1]}}, immRaw};

      case (instr.op)
         opAdd,
         opSub,
         opAnd,
         opOr,
         opXor,
         opShl,
         opShr: begin
            ctrl.regWrite  = 1'b1;
            ctrl.flagWrite = 1'b1;
         end
         opMovi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.useImm    = 1'b1;
         end
         opAddi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.flagWrite = 1'b1;
            ctrl.useImm    = 1'b1;
         end
         opCmp: begin
            ctrl.flagWrite = 1'b1;              // result is dropped
         end
         opMovz: begin
            ctrl.regWrite  = 1'b1;
            ctrl.condZero  = 1'b1;
         end
         default: begin
            // unused opcodes behave as NOP
            ctrl.regWrite  = 1'b0;
            ctrl.flagWrite = 1'b0;
         end
      endcase
   end

endmodule

// ==== design/operandFetch.sv ====
`timescale 1ns/1ps

module operandFetch (
   input  logic                      CLK,
   input  logic                      rstN,
   input  corePkg::ctrl_t            ctrl,
   input  corePkg::wb_t              exFwd,   // result still in execute
   input  corePkg::wb_t              wbIn,    // registered writeback
   output logic [corePkg::dataW-1:0] opA,
   output logic [corePkg::dataW-1:0] opB
);
   import corePkg::*;

   logic [dataW-1:0] regFile [numRegs];
   logic [dataW-1:0] readB;

   // ------------------------------------------------------------------------
   // register file
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regFile[i] <= '0;
         end
      end else if (wbIn.valid && wbIn.regWrite) begin
         regFile[wbIn.rd] <= wbIn.data;
      end
   end

   // ------------------------------------------------------------------------
   // forwarding
   // ------------------------------------------------------------------------
   // execute beats writeback and both beat the array
   function automatic logic [dataW-1:0] resolve(
      input logic [regAddrW-1:0] addr,
      input wb_t                 exSrc,
      input wb_t                 wbSrc,
      input logic [dataW-1:0]    rfVal
   );
      logic [dataW-1:0] value;
      value = rfVal;
      if (wbSrc.valid && wbSrc.regWrite && wbSrc.rd == addr) begin
         value = wbSrc.data;
      end
      if (exSrc.valid && exSrc.regWrite && exSrc.rd == addr) begin
         value = exSrc.data;
      end
      return value;
   endfunction

   always_comb begin
      opA   = resolve(ctrl.ra, exFwd, wbIn, regFile[ctrl.ra]);
      readB = resolve(ctrl.rb, exFwd, wbIn, regFile[ctrl.rb]);
      opB   = ctrl.useImm ? ctrl.imm : readB;
   end

   // writeback address comes from two stages back and must be clean
   wrAddrKnown: assert property (
      @(posedge CLK) disable iff (!rstN)
      (wbIn.valid && wbIn.regWrite) |-> !$isunknown(wbIn.rd)
   );

endmodule

// ==== design/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
   parameter type payload_t = logic
) (
   input  logic     CLK,
   input  logic     rstN,
   input  payload_t d,
   output payload_t q
);

   // all-zero reset leaves every valid bit low
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         q <= '0;
      end else begin
         q <= d;
      end
   end

   // upstream stages must never hand over X, even in a bubble
   qKnown: assert property (
      @(posedge CLK) disable iff (!rstN)
      !$isunknown(q)
   );

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
   input  logic              CLK,
   input  logic              rstN,
   input  corePkg::exStage_t ex,
   output corePkg::wb_t      wbOut,
   output corePkg::flags_t   flags
);
   import corePkg::*;

   logic [dataW-1:0]  a;
   logic [dataW-1:0]  b;
   logic [shamtW-1:0] shamt;
   logic [dataW-1:0]  result;
   logic              carry;
   logic              condOk;
   flags_t            flagsQ;

   assign a     = ex.opA;
   assign b     = ex.opB;
   assign shamt = b[shamtW-1:0];

   // ------------------------------------------------------------------------
   // ALU
   // ------------------------------------------------------------------------
   always_comb begin
      result = '0;
      carry  = 1'b0;                            // logic and shifts clear C
      case (ex.ctrl.op)
         opAdd,
         opAddi: {carry, result} = {1'b0, a} + {1'b0, b};
         opSub,
         opCmp: begin
            result = a - b;
            carry  = (a < b);                   // borrow
         end
         opAnd:  result = a & b;
         opOr:   result = a | b;
         opXor:  result = a ^ b;
         opShl:  result = a << shamt;
         opShr:  result = a >> shamt;
         opMovi: result = b;                    // b holds the immediate
         opMovz: result = a;
         default: result = '0;
      endcase
   end

   // MOVZ looks at Z as left by the instruction before it
   assign condOk = !ex.ctrl.condZero || flagsQ.z;

   always_comb begin
      wbOut          = '0;
      wbOut.valid    = ex.valid;
      wbOut.regWrite = ex.valid && ex.ctrl.regWrite && condOk;
      wbOut.rd       = ex.ctrl.rd;
      wbOut.data     = result;
   end

   // ------------------------------------------------------------------------
   // flags
   // ------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         flagsQ <= '0;
      end else if (ex.valid && ex.ctrl.flagWrite) begin
         flagsQ.z <= (result == '0);
         flagsQ.n <= result[dataW-1];
         flagsQ.c <= carry;
      end
   end

   assign flags = flagsQ;

   // a conditional move must not also change the flags it depends on
   noFlagCond: assert property (
      @(posedge CLK) disable iff (!rstN)
      ex.valid |-> !(ex.ctrl.flagWrite && ex.ctrl.condZero)
   );

endmodule

// ==== design/coreTop.sv ====
`timescale 1ns/1ps

module coreTop (
   input  logic            CLK,
   input  logic            rstN,
   input  logic            instrValid,
   input  corePkg::instr_t instr,
   output corePkg::wb_t    wb,
   output corePkg::flags_t flags
);
   import corePkg::*;

   ctrl_t            ctrl;
   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;
   exStage_t         exD;
   exStage_t         exQ;
   wb_t              exWb;                      // combinational execute result

   // ------------------------------------------------------------------------
   // decode and operand fetch
   // ------------------------------------------------------------------------
   instrDecoder instrDecoder_i (
      .instr (instr),
      .ctrl  (ctrl)
   );

   operandFetch operandFetch_i (
      .CLK   (CLK),
      .rstN  (rstN),
      .ctrl  (ctrl),
      .exFwd (exWb),
      .wbIn  (wb),
      .opA   (opA),
      .opB   (opB)
   );

   assign exD = '{valid: instrValid, ctrl: ctrl, opA: opA, opB: opB};

   // ------------------------------------------------------------------------
   // execute and writeback
   // ------------------------------------------------------------------------
   stageReg #(.payload_t(exStage_t)) exReg_i (
      .CLK  (CLK),
      .rstN (rstN),
      .d    (exD),
      .q    (exQ)
   );

   executeUnit executeUnit_i (
      .CLK   (CLK),
      .rstN  (rstN),
      .ex    (exQ),
      .wbOut (exWb),
      .flags (flags)
   );

   stageReg #(.payload_t(wb_t)) wbReg_i (
      .CLK  (CLK),
      .rstN (rstN),
      .d    (exWb),
      .q    (wb)                                // also the register file write port
   );

endmodule

// ==== test/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;
   import corePkg::*;

   localparam int maxCycles = 500;

   typedef struct packed {
      logic   valid;
      instr_t instr;
      wb_t    wb;
      flags_t flags;                            // flags after this row as {z, n, c}
   } row_t;

   logic   CLK;
   logic   rstN;
   logic   instrValid;
   instr_t instr;
   wb_t    wb;
   flags_t flags;
   row_t   rows[$];

   coreTop coreTop_i (
      .CLK        (CLK),
      .rstN       (rstN),
      .instrValid (instrValid),
      .instr      (instr),
      .wb         (wb),
      .flags      (flags)
   );

   always #2 CLK = ~CLK;

   // ------------------------------------------------------------------------
   // failure and watchdog
   // ------------------------------------------------------------------------
   task automatic stopOnFailure();
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   initial begin
      repeat (maxCycles) @(posedge CLK);
      $display("timeout: program did not finish within %0d cycles", maxCycles);
      stopOnFailure();
   end

   // ------------------------------------------------------------------------
   // program encoding
   // ------------------------------------------------------------------------
   function automatic instr_t encReg(opcode_t op, int rd, int ra, int rb);
      instr_t w;
      w       = '0;
      w.op    = op;
      w.rd    = rd[regAddrW-1:0];
      w.ra    = ra[regAddrW-1:0];
      w.rb    = rb[regAddrW-1:0];
      return w;
   endfunction

   function automatic instr_t encImm(opcode_t op, int rd, int ra, int imm);
      instr_t          w;
      logic [immW-1:0] v;
      v       = imm[immW-1:0];                  // 6-bit two's complement
      w       = '0;
      w.op    = op;
      w.rd    = rd[regAddrW-1:0];
      w.ra    = ra[regAddrW-1:0];
      w.rb    = v[5:3];
      w.immLo = v[2:0];
      return w;
   endfunction

   function automatic wb_t writes(int rd, int data);
      wb_t e;
      e          = '0;
      e.valid    = 1'b1;
      e.regWrite = 1'b1;
      e.rd       = rd[regAddrW-1:0];
      e.data     = data[dataW-1:0];
      return e;
   endfunction

   function automatic wb_t noWrite();
      wb_t e;
      e       = '0;
      e.valid = 1'b1;
      return e;
   endfunction

   task automatic issue(instr_t w, wb_t e, flags_t f);
      rows.push_back('{valid: 1'b1, instr: w, wb: e, flags: f});
   endtask

   task automatic bubble(instr_t w, flags_t f);
      rows.push_back('{valid: 1'b0, instr: w, wb: '0, flags: f});
   endtask

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   task automatic checkWb(input wb_t got, input wb_t exp, input int row);
      if (got.valid !== exp.valid) begin
         $display("MISMATCH wb.valid row %0d: expected %h, got %h", row, exp.valid, got.valid);
         stopOnFailure();
      end
      if (exp.valid && got.regWrite !== exp.regWrite) begin
         $display("MISMATCH wb.regWrite row %0d: expected %h, got %h", row, exp.regWrite,
                  got.regWrite);
         stopOnFailure();
      end
      if (exp.valid && exp.regWrite) begin // address and data only matter on a write
         if (got.rd !== exp.rd || got.data !== exp.data) begin
            $display("MISMATCH wb.rd/wb.data row %0d: expected %h/%h, got %h/%h", row,
                     exp.rd, exp.data, got.rd, got.data);
            stopOnFailure();
         end
      end
   endtask

   task automatic checkFlags(input flags_t got, input flags_t exp, input int row);
      if (got !== exp) begin
         $display("MISMATCH flags row %0d: expected %h, got %h", row, exp, got);
         stopOnFailure();
      end
   endtask

   // ------------------------------------------------------------------------
   // program with expected results worked out by hand
   // ------------------------------------------------------------------------
   task automatic buildProgram();
      issue(encReg(opAdd, 0, 0, 0), writes(0, 16'h0000), flags_t'(3'b100)); // reset values
      issue(encReg(opAdd, 5, 5, 5), writes(5, 16'h0000), flags_t'(3'b100));
      issue(encReg(opAdd, 7, 7, 7), writes(7, 16'h0000), flags_t'(3'b100));
      issue(encImm(opMovi, 1, 0, 5), writes(1, 16'h0005), flags_t'(3'b100));
      issue(encImm(opMovi, 2, 0, 3), writes(2, 16'h0003), flags_t'(3'b100));
      issue(encReg(opAdd, 3, 1, 2), writes(3, 16'h0008), flags_t'(3'b000));
      issue(encReg(opSub, 4, 1, 2), writes(4, 16'h0002), flags_t'(3'b000));
      issue(encReg(opSub, 4, 2, 1), writes(4, 16'hfffe), flags_t'(3'b011)); // borrow
      issue(encReg(opAnd, 5, 1, 2), writes(5, 16'h0001), flags_t'(3'b000));
      issue(encReg(opOr, 5, 1, 2), writes(5, 16'h0007), flags_t'(3'b000));
      issue(encReg(opXor, 5, 1, 2), writes(5, 16'h0006), flags_t'(3'b000));
      issue(encReg(opXor, 6, 1, 1), writes(6, 16'h0000), flags_t'(3'b100));
      issue(encReg(opShl, 6, 1, 2), writes(6, 16'h0028), flags_t'(3'b000));
      issue(encImm(opMovi, 6, 0, -1), writes(6, 16'hffff), flags_t'(3'b000));
      issue(encReg(opShr, 5, 6, 2), writes(5, 16'h1fff), flags_t'(3'b000));
      issue(encImm(opMovi, 2, 0, 1), writes(2, 16'h0001), flags_t'(3'b000));
      issue(encReg(opAdd, 5, 6, 2), writes(5, 16'h0000), flags_t'(3'b101)); // carry out
      issue(encImm(opAddi, 5, 1, -6), writes(5, 16'hffff), flags_t'(3'b010));
      issue(encImm(opAddi, 3, 6, 2), writes(3, 16'h0001), flags_t'(3'b001));
      issue(encImm(opMovi, 4, 0, 20), writes(4, 16'h0014), flags_t'(3'b001));
      issue(encReg(opShl, 3, 2, 4), writes(3, 16'h0010), flags_t'(3'b000)); // shamt 4
      issue(encReg(opShl, 3, 6, 4), writes(3, 16'hfff0), flags_t'(3'b010));
      // dependency chains at distance one and two
      issue(encImm(opMovi, 1, 0, 7), writes(1, 16'h0007), flags_t'(3'b010));
      issue(encReg(opAdd, 2, 1, 1), writes(2, 16'h000e), flags_t'(3'b000));
      issue(encReg(opAdd, 3, 2, 1), writes(3, 16'h0015), flags_t'(3'b000));
      issue(encReg(opSub, 4, 3, 2), writes(4, 16'h0007), flags_t'(3'b000));
      bubble(encReg(opAdd, 1, 4, 4), flags_t'(3'b000));
      issue(encReg(opAdd, 5, 4, 3), writes(5, 16'h001c), flags_t'(3'b000));
      // CMP and a read of its target
      issue(encReg(opCmp, 5, 4, 4), noWrite(), flags_t'(3'b100));
      issue(encReg(opAdd, 6, 5, 0), writes(6, 16'h001c), flags_t'(3'b000));
      issue(encReg(opCmp, 0, 4, 5), noWrite(), flags_t'(3'b011));
      issue(encReg(opAdd, 6, 0, 0), writes(6, 16'h0000), flags_t'(3'b100));
      // MOVZ taken and not taken
      issue(encReg(opMovz, 7, 4, 0), writes(7, 16'h0007), flags_t'(3'b100));
      issue(encReg(opCmp, 0, 4, 0), noWrite(), flags_t'(3'b000));
      issue(encReg(opMovz, 7, 1, 0), noWrite(), flags_t'(3'b000));
      issue(encReg(opAdd, 6, 7, 0), writes(6, 16'h0007), flags_t'(3'b000));
      issue(encReg(opSub, 0, 4, 4), writes(0, 16'h0000), flags_t'(3'b100));
      issue(encReg(opMovz, 7, 3, 0), writes(7, 16'h0015), flags_t'(3'b100));
      issue(encReg(opAdd, 6, 7, 7), writes(6, 16'h002a), flags_t'(3'b000));
      // undefined opcodes and bubbles leave registers and flags alone
      issue(encReg(opCmp, 0, 0, 4), noWrite(), flags_t'(3'b011));
      issue(encReg(opcode_t'(4'd11), 1, 0, 0), noWrite(), flags_t'(3'b011));
      bubble(encReg(opAdd, 1, 4, 4), flags_t'(3'b011));
      issue(encReg(opcode_t'(4'd15), 2, 4, 4), noWrite(), flags_t'(3'b011));
      issue(encReg(opcode_t'(4'd13), 3, 0, 0), noWrite(), flags_t'(3'b011));
      bubble(encReg(opSub, 2, 0, 4), flags_t'(3'b011));
      issue(encReg(opAdd, 6, 1, 2), writes(6, 16'h0015), flags_t'(3'b000));
      issue(encReg(opAdd, 6, 3, 7), writes(6, 16'h002a), flags_t'(3'b000));
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      row_t r;
      CLK        = 1'b0;
      rstN       <= 1'b0;
      instrValid <= 1'b0;
      instr      <= '0;
      buildProgram();

      repeat (5) @(posedge CLK);
      rstN <= 1'b1;
      @(negedge CLK);
      checkWb(wb, '0, -1);
      checkFlags(flags, '0, -1);

      // row i is driven now and comes out of writeback two edges later
      for (int i = 0; i < rows.size() + 2; i++) begin
         @(posedge CLK);
         if (i < rows.size()) begin
            r          = rows[i];
            instrValid <= r.valid;
            instr      <= r.instr;
         end else begin
            instrValid <= 1'b0;                 // drain
            instr      <= '0;
         end
         @(negedge CLK);
         if (i >= 2) begin
            r = rows[i-2];
            checkWb(wb, r.wb, i - 2);
            checkFlags(flags, r.flags, i - 2);
         end
      end

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== vlog.f ====
design/corePkg.sv
design/instrDecoder.sv
design/operandFetch.sv
design/stageReg.sv
design/executeUnit.sv
design/coreTop.sv
test/coreTb.sv

// ==== Makefile ====
TOP := coreTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

obj_dir/V$(TOP): vlog.f design/*.sv test/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) --Mdir obj_dir

# a failing run ends in $fatal, which gives a nonzero exit status
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
